// ==== order_gen_pkg.sv ====
package order_gen_pkg;

    localparam int NUM_PE   = 10;
    localparam int PE_IDX_W = 4;
    localparam int DATA_W   = 256;
    localparam int KEEP_W   = DATA_W / 8;
    localparam int ORD_ID_W = 32;

    localparam logic [ORD_ID_W-1:0] ORD_ID_MAX = 32'd9_999_999;

    // beat 0 carries 200 bits, beat 1 carries 240 bits.
    localparam logic [KEEP_W-1:0] HDR_KEEP  = 32'h01ff_ffff;
    localparam logic [KEEP_W-1:0] BODY_KEEP = 32'h3fff_ffff;

    typedef struct packed {
        logic [7:0]   exec_type;
        logic [7:0]   symbol_type;
        logic [159:0] sym;
        logic [31:0]  price;
        logic [15:0]  qty;
        logic [7:0]   side;
        logic [7:0]   ord_type;
        logic [7:0]   time_in_force;
    } order_t;

    typedef struct packed {
        logic [15:0] session_id;
        logic [31:0] msg_seq_num;
        logic [31:0] epoch_s;
        logic [15:0] ms;
        logic [15:0] cm_id;
        logic [31:0] investor_acno;
        logic [7:0]  investor_flag;
        logic [7:0]  order_source;
    } header_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_HDR,
        SER_BODY
    } ser_state_e;

    // session header, exec type and order id, lowest field at bit 0.
    function automatic logic [DATA_W-1:0] pack_hdr_beat(
        input header_t             hdr,
        input logic [7:0]          exec_type,
        input logic [ORD_ID_W-1:0] ord_id
    );
        return {56'd0,
                ord_id,
                exec_type,
                hdr.order_source,
                hdr.investor_flag,
                hdr.investor_acno,
                hdr.cm_id,
                hdr.ms,
                hdr.epoch_s,
                hdr.msg_seq_num,
                hdr.session_id};
    endfunction

    // remaining order fields, exec type already sent in beat 0.
    function automatic logic [DATA_W-1:0] pack_body_beat(input order_t ord);
        return {16'd0,
                ord.time_in_force,
                ord.ord_type,
                ord.side,
                ord.qty,
                ord.price,
                ord.sym,
                ord.symbol_type};
    endfunction

endpackage

// ==== axis_if.sv ====
`timescale 1ns/10ps

interface axis_if;

    logic                               tvalid;
    logic                               tready;
    logic [order_gen_pkg::DATA_W-1:0]   tdata;
    logic                               tlast;
    logic [order_gen_pkg::KEEP_W-1:0]   tkeep;
    logic [order_gen_pkg::KEEP_W-1:0]   tstrb;

    modport src (
        output tvalid,
        input  tready,
        output tdata,
        output tlast,
        output tkeep,
        output tstrb
    );

    modport snk (
        input  tvalid,
        output tready,
        input  tdata,
        input  tlast,
        input  tkeep,
        input  tstrb
    );

endinterface

// ==== order_buffer.sv ====
`timescale 1ns/10ps

module order_buffer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid_i,
    input  order_gen_pkg::order_t order_i,
    input  logic                  ack_i,
    output logic                  pending_o,
    output order_gen_pkg::order_t order_o
);

    logic                  pending_q;
    order_gen_pkg::order_t order_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending_q <= 1'b0;
        end else if (valid_i) begin
            pending_q <= 1'b1;   // new order beats a same-cycle ack.
        end else if (ack_i) begin
            pending_q <= 1'b0;
        end
    end

    // latest order wins while still pending.
    always_ff @(posedge clk) begin
        if (valid_i) begin
            order_q <= order_i;
        end
    end

    assign pending_o = pending_q;
    assign order_o   = order_q;

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [order_gen_pkg::NUM_PE-1:0]   pending_i,
    input  order_gen_pkg::order_t              orders_i [order_gen_pkg::NUM_PE],
    input  logic                               ready_i,
    output logic [order_gen_pkg::NUM_PE-1:0]   ack_o,
    output logic                               grant_o,
    output order_gen_pkg::order_t              order_o
);

    localparam int IDX_W = order_gen_pkg::PE_IDX_W;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] sel;
    logic             found;

    // first pending engine strictly after the pointer, wrapping.
    always_comb begin
        logic [IDX_W:0] cand;
        found = 1'b0;
        sel   = ptr_q;
        for (int k = 1; k <= order_gen_pkg::NUM_PE; k++) begin
            cand = {1'b0, ptr_q} + (IDX_W+1)'(k);
            if (cand >= (IDX_W+1)'(order_gen_pkg::NUM_PE)) begin
                cand = cand - (IDX_W+1)'(order_gen_pkg::NUM_PE);
            end
            if (!found && pending_i[cand[IDX_W-1:0]]) begin
                found = 1'b1;
                sel   = cand[IDX_W-1:0];
            end
        end
    end

    assign grant_o = ready_i && found;
    assign order_o = orders_i[sel];

    always_comb begin
        ack_o = '0;
        if (grant_o) begin
            ack_o[sel] = 1'b1;   // one-hot.
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ptr_q <= IDX_W'(order_gen_pkg::NUM_PE - 1);   // engine 0 goes first.
        end else if (grant_o) begin
            ptr_q <= sel;
        end
    end

endmodule

// ==== payload_serializer.sv ====
`timescale 1ns/10ps

module payload_serializer (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   grant_i,
    input  order_gen_pkg::order_t  order_i,
    input  order_gen_pkg::header_t header_i,
    output logic                   ready_o,
    axis_if.src                    axis
);

    localparam int ID_W = order_gen_pkg::ORD_ID_W;

    order_gen_pkg::ser_state_e state_q;
    logic [ID_W-1:0]           ord_id_q;

    order_gen_pkg::header_t    hdr_q;
    order_gen_pkg::order_t     order_q;
    logic [ID_W-1:0]           msg_id_q;

    logic                      beat_done;

    assign beat_done = axis.tvalid && axis.tready;
    assign ready_o   = (state_q == order_gen_pkg::SER_IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= order_gen_pkg::SER_IDLE;
        end else begin
            case (state_q)
                order_gen_pkg::SER_IDLE: begin
                    if (grant_i) begin
                        state_q <= order_gen_pkg::SER_HDR;
                    end
                end
                order_gen_pkg::SER_HDR: begin
                    if (beat_done) begin
                        state_q <= order_gen_pkg::SER_BODY;
                    end
                end
                order_gen_pkg::SER_BODY: begin
                    if (beat_done) begin
                        state_q <= order_gen_pkg::SER_IDLE;
                    end
                end
                default: begin
                    state_q <= order_gen_pkg::SER_IDLE;
                end
            endcase
        end
    end

    // running order id, one per grant.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ord_id_q <= '0;
        end else if (grant_i) begin
            if (ord_id_q == order_gen_pkg::ORD_ID_MAX) begin
                ord_id_q <= '0;
            end else begin
                ord_id_q <= ord_id_q + 1'b1;
            end
        end
    end

    // message snapshot, held for both beats.
    always_ff @(posedge clk) begin
        if (grant_i) begin
            hdr_q    <= header_i;
            order_q  <= order_i;
            msg_id_q <= ord_id_q;
        end
    end

    // stream outputs decode from registers only, so they hold under stall.
    always_comb begin
        axis.tvalid = 1'b0;
        axis.tlast  = 1'b0;
        axis.tdata  = '0;
        axis.tkeep  = '0;
        axis.tstrb  = '0;
        case (state_q)
            order_gen_pkg::SER_HDR: begin
                axis.tvalid = 1'b1;
                axis.tdata  = order_gen_pkg::pack_hdr_beat(hdr_q, order_q.exec_type,
                                                           msg_id_q);
                axis.tkeep  = order_gen_pkg::HDR_KEEP;
                axis.tstrb  = order_gen_pkg::HDR_KEEP;
            end
            order_gen_pkg::SER_BODY: begin
                axis.tvalid = 1'b1;
                axis.tlast  = 1'b1;   // two-beat message.
                axis.tdata  = order_gen_pkg::pack_body_beat(order_q);
                axis.tkeep  = order_gen_pkg::BODY_KEEP;
                axis.tstrb  = order_gen_pkg::BODY_KEEP;
            end
            default: begin
                axis.tvalid = 1'b0;
            end
        endcase
    end

endmodule

// ==== order_payload_top.sv ====
`timescale 1ns/10ps

module order_payload_top (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [order_gen_pkg::NUM_PE-1:0]   pe_valid_i,
    input  order_gen_pkg::order_t              pe_order_i [order_gen_pkg::NUM_PE],
    input  order_gen_pkg::header_t             header_i,
    input  logic                               tready_i,
    output logic [order_gen_pkg::NUM_PE-1:0]   pe_ack_o,
    output logic                               tvalid_o,
    output logic [order_gen_pkg::DATA_W-1:0]   tdata_o,
    output logic                               tlast_o,
    output logic [order_gen_pkg::KEEP_W-1:0]   tkeep_o,
    output logic [order_gen_pkg::KEEP_W-1:0]   tstrb_o
);

    logic [order_gen_pkg::NUM_PE-1:0] pending;
    order_gen_pkg::order_t            held_order [order_gen_pkg::NUM_PE];
    logic [order_gen_pkg::NUM_PE-1:0] ack;
    logic                             grant;
    order_gen_pkg::order_t            sel_order;
    logic                             ser_ready;

    axis_if axis_s ();

    for (genvar g = 0; g < order_gen_pkg::NUM_PE; g++) begin : g_buf
        order_buffer i_order_buffer (
            .clk       (clk),
            .resetn    (resetn),
            .valid_i   (pe_valid_i[g]),
            .order_i   (pe_order_i[g]),
            .ack_i     (ack[g]),
            .pending_o (pending[g]),
            .order_o   (held_order[g])
        );
    end

    rr_arbiter i_rr_arbiter (
        .clk       (clk),
        .resetn    (resetn),
        .pending_i (pending),
        .orders_i  (held_order),
        .ready_i   (ser_ready),
        .ack_o     (ack),
        .grant_o   (grant),
        .order_o   (sel_order)
    );

    payload_serializer i_payload_serializer (
        .clk      (clk),
        .resetn   (resetn),
        .grant_i  (grant),
        .order_i  (sel_order),
        .header_i (header_i),
        .ready_o  (ser_ready),
        .axis     (axis_s.src)
    );

    assign pe_ack_o = ack;

    // sink side of the stream maps onto the plain ports.
    assign axis_s.tready = tready_i;
    assign tvalid_o      = axis_s.tvalid;
    assign tdata_o       = axis_s.tdata;
    assign tlast_o       = axis_s.tlast;
    assign tkeep_o       = axis_s.tkeep;
    assign tstrb_o       = axis_s.tstrb;

endmodule

// ==== payload_checker.sv ====
`timescale 1ns/10ps

module payload_checker (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [order_gen_pkg::NUM_PE-1:0]   pe_valid_i,
    input  order_gen_pkg::order_t              pe_order_i [order_gen_pkg::NUM_PE],
    input  order_gen_pkg::header_t             header_i,
    input  logic                               tready_i,
    input  logic [order_gen_pkg::NUM_PE-1:0]   pe_ack_i,
    input  logic                               tvalid_i,
    input  logic [order_gen_pkg::DATA_W-1:0]   tdata_i,
    input  logic                               tlast_i,
    input  logic [order_gen_pkg::KEEP_W-1:0]   tkeep_i,
    input  logic [order_gen_pkg::KEEP_W-1:0]   tstrb_i,
    output int                                 msg_cnt_o,
    output int                                 err_cnt_o
);

    localparam int          NUM_PE = order_gen_pkg::NUM_PE;
    localparam logic [31:0] ID_MAX = 32'd9_999_999;
    localparam logic [31:0] KEEP0  = 32'((64'd1 << 25) - 1);   // 25 byte lanes.
    localparam logic [31:0] KEEP1  = 32'((64'd1 << 30) - 1);   // 30 byte lanes.

    logic [NUM_PE-1:0]         pend_m;
    order_gen_pkg::order_t     held_m [NUM_PE];
    int                        ptr_m;
    int                        st_m;   // 0 idle, 1 header beat, 2 body beat.
    logic [31:0]               id_m;
    logic [255:0]              exp_hdr_q [$];
    logic [255:0]              exp_body_q [$];
    logic                      stalled_prev;
    logic [321:0]              stream_prev;

    initial begin
        msg_cnt_o = 0;
        err_cnt_o = 0;
    end

    task automatic report_mismatch(input string what);
        err_cnt_o++;
        $display("[FAIL] %0t ns: %s", $time, what);
    endtask

    function automatic logic [255:0] expect_hdr_beat(input order_gen_pkg::header_t h,
                                                     input logic [7:0] ex,
                                                     input logic [31:0] id);
        logic [255:0] b;
        b          = '0;
        b[15:0]    = h.session_id;
        b[47:16]   = h.msg_seq_num;
        b[79:48]   = h.epoch_s;
        b[95:80]   = h.ms;
        b[111:96]  = h.cm_id;
        b[143:112] = h.investor_acno;
        b[151:144] = h.investor_flag;
        b[159:152] = h.order_source;
        b[167:160] = ex;
        b[199:168] = id;
        return b;
    endfunction

    function automatic logic [255:0] expect_body_beat(input order_gen_pkg::order_t o);
        logic [255:0] b;
        b          = '0;
        b[7:0]     = o.symbol_type;
        b[167:8]   = o.sym;
        b[199:168] = o.price;
        b[215:200] = o.qty;
        b[223:216] = o.side;
        b[231:224] = o.ord_type;
        b[239:232] = o.time_in_force;
        return b;
    endfunction

    // everything settles by the falling edge, the model then steps one cycle.
    always @(negedge clk) begin : sample
        logic [NUM_PE-1:0] exp_ack;
        int                sel;
        int                idx;
        if (resetn !== 1'b1) begin
            pend_m       = '0;
            ptr_m        = NUM_PE - 1;
            st_m         = 0;
            id_m         = '0;
            stalled_prev = 1'b0;
            exp_hdr_q.delete();
            exp_body_q.delete();
        end else begin
            exp_ack = '0;
            sel     = -1;
            if (st_m == 0) begin
                for (int k = 1; k <= NUM_PE; k++) begin
                    idx = (ptr_m + k) % NUM_PE;
                    if (sel < 0 && pend_m[idx]) begin
                        sel = idx;
                    end
                end
            end
            if (sel >= 0) begin
                exp_ack[sel] = 1'b1;
            end
            if (pe_ack_i !== exp_ack) begin
                report_mismatch($sformatf("ack %b, expected %b", pe_ack_i, exp_ack));
            end
            if (tvalid_i !== (st_m != 0)) begin
                report_mismatch($sformatf("tvalid %b in model state %0d", tvalid_i, st_m));
            end
            if (st_m == 1) begin
                if (tdata_i !== exp_hdr_q[0] || tlast_i !== 1'b0
                    || tkeep_i !== KEEP0 || tstrb_i !== KEEP0) begin
                    report_mismatch($sformatf("beat 0 of message %0d: tdata %h tlast %b",
                                              msg_cnt_o, tdata_i, tlast_i));
                end
            end else if (st_m == 2) begin
                if (tdata_i !== exp_body_q[0] || tlast_i !== 1'b1
                    || tkeep_i !== KEEP1 || tstrb_i !== KEEP1) begin
                    report_mismatch($sformatf("beat 1 of message %0d: tdata %h tlast %b",
                                              msg_cnt_o, tdata_i, tlast_i));
                end
            end else if (tlast_i !== 1'b0) begin
                report_mismatch("tlast high with no message on the stream");
            end
            if (stalled_prev
                && {tvalid_i, tlast_i, tkeep_i, tstrb_i, tdata_i} !== stream_prev) begin
                report_mismatch("stream signals changed while stalled");
            end
            stalled_prev = tvalid_i && !tready_i;
            stream_prev  = {tvalid_i, tlast_i, tkeep_i, tstrb_i, tdata_i};

            case (st_m)
                0: begin
                    if (sel >= 0) begin
                        exp_hdr_q.push_back(expect_hdr_beat(header_i,
                                                            held_m[sel].exec_type, id_m));
                        exp_body_q.push_back(expect_body_beat(held_m[sel]));
                        id_m  = (id_m == ID_MAX) ? 32'd0 : id_m + 32'd1;
                        ptr_m = sel;
                        st_m  = 1;
                    end
                end
                1: begin
                    if (tready_i) begin
                        st_m = 2;
                    end
                end
                default: begin
                    if (tready_i) begin
                        exp_hdr_q.delete(0);
                        exp_body_q.delete(0);
                        msg_cnt_o++;
                        st_m = 0;
                    end
                end
            endcase

            for (int i = 0; i < NUM_PE; i++) begin
                if (pe_valid_i[i]) begin
                    pend_m[i] = 1'b1;   // newest order wins.
                    held_m[i] = pe_order_i[i];
                end else if (exp_ack[i]) begin
                    pend_m[i] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb_order_payload.sv ====
`timescale 1ns/10ps

module tb_order_payload;

    localparam int NUM_PE     = order_gen_pkg::NUM_PE;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS   = 8;
    localparam int ROW_CYCLES = 200;
    localparam int SETTLE     = 8;

    typedef struct {
        string                  name;
        logic [NUM_PE-1:0]      valid_mask;
        logic [NUM_PE-1:0]      second_mask;   // re-pulse while still pending.
        order_gen_pkg::header_t hdr;
        int                     stall_pct;
        int                     exp_msgs;
    } row_t;

    logic                                clk;
    logic                                resetn;
    logic [NUM_PE-1:0]                   pe_valid;
    order_gen_pkg::order_t               pe_order [NUM_PE];
    order_gen_pkg::header_t              header;
    logic                                tready;
    logic [NUM_PE-1:0]                   pe_ack;
    logic                                tvalid;
    logic [order_gen_pkg::DATA_W-1:0]    tdata;
    logic                                tlast;
    logic [order_gen_pkg::KEEP_W-1:0]    tkeep;
    logic [order_gen_pkg::KEEP_W-1:0]    tstrb;
    int                                  msg_cnt;
    int                                  err_cnt;

    row_t rows [NUM_ROWS];

    order_payload_top i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .pe_valid_i (pe_valid),
        .pe_order_i (pe_order),
        .header_i   (header),
        .tready_i   (tready),
        .pe_ack_o   (pe_ack),
        .tvalid_o   (tvalid),
        .tdata_o    (tdata),
        .tlast_o    (tlast),
        .tkeep_o    (tkeep),
        .tstrb_o    (tstrb)
    );

    payload_checker i_checker (
        .clk        (clk),
        .resetn     (resetn),
        .pe_valid_i (pe_valid),
        .pe_order_i (pe_order),
        .header_i   (header),
        .tready_i   (tready),
        .pe_ack_i   (pe_ack),
        .tvalid_i   (tvalid),
        .tdata_i    (tdata),
        .tlast_i    (tlast),
        .tkeep_i    (tkeep),
        .tstrb_i    (tstrb),
        .msg_cnt_o  (msg_cnt),
        .err_cnt_o  (err_cnt)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic order_gen_pkg::header_t build_header(input logic [31:0] base);
        order_gen_pkg::header_t h;
        h.session_id    = base[15:0];
        h.msg_seq_num   = base ^ 32'h0f0f_0f0f;
        h.epoch_s       = ~base;
        h.ms            = base[31:16];
        h.cm_id         = base[15:0] ^ 16'h5a5a;
        h.investor_acno = base * 32'd3;
        h.investor_flag = base[7:0] + 8'd1;
        h.order_source  = base[31:24];
        return h;
    endfunction

    function automatic order_gen_pkg::order_t random_order();
        order_gen_pkg::order_t o;
        o.exec_type     = 8'($urandom);
        o.symbol_type   = 8'($urandom);
        o.sym           = {$urandom, $urandom, $urandom, $urandom, $urandom};
        o.price         = $urandom;
        o.qty           = 16'($urandom);
        o.side          = 8'($urandom);
        o.ord_type      = 8'($urandom);
        o.time_in_force = 8'($urandom);
        return o;
    endfunction

    task automatic set_row(input int idx, input string name, input logic [NUM_PE-1:0] vmask,
                           input logic [NUM_PE-1:0] smask, input logic [31:0] hbase,
                           input int stall, input int msgs);
        rows[idx].name        = name;
        rows[idx].valid_mask  = vmask;
        rows[idx].second_mask = smask;
        rows[idx].hdr         = build_header(hbase);
        rows[idx].stall_pct   = stall;
        rows[idx].exp_msgs    = msgs;
    endtask

    // one-cycle valid on the masked engines with fresh orders.
    task automatic pulse_engines(input logic [NUM_PE-1:0] mask);
        for (int i = 0; i < NUM_PE; i++) begin
            if (mask[i]) begin
                pe_order[i] = random_order();
            end
        end
        pe_valid = mask;
        @(posedge clk);
        #1;
        pe_valid = '0;
    endtask

    task automatic wait_messages(input int target, input int stall_pct);
        while (msg_cnt < target) begin
            @(posedge clk);
            #1;
            tready = ($urandom_range(99) >= stall_pct);
            header = build_header($urandom);   // session fields move on mid-message.
        end
        tready = 1'b1;
    endtask

    initial begin
        int unsigned seed_v;
        int unsigned dummy;
        int          total_exp;
        int          err_before;
        int          rows_ok;
        int          rows_bad;
        bit          row_bad;
        seed_v    = 32'h9f0d_3b23;
        dummy     = $urandom(seed_v);
        total_exp = 0;
        rows_ok   = 0;
        rows_bad  = 0;
        // arbitration order below follows the pointer carried over from each row.
        set_row(0, "idle",            10'b00_0000_0000, 10'b00_0000_0000, 32'h1111_0001, 0, 0);
        set_row(1, "single",          10'b00_0000_1000, 10'b00_0000_0000, 32'h2222_0002, 0, 1);
        set_row(2, "all_engines",     10'b11_1111_1111, 10'b00_0000_0000, 32'h3333_0003, 0, 10);
        set_row(3, "multi_stall",     10'b10_1001_0110, 10'b00_0000_0000, 32'h4444_0004, 40, 5);
        set_row(4, "overwrite",       10'b01_0010_0001, 10'b01_0000_0001, 32'h5555_0005, 0, 3);
        set_row(5, "overwrite_stall", 10'b00_0100_0010, 10'b00_0100_0000, 32'h6666_0006, 30, 2);
        set_row(6, "random_stall",    10'b11_1111_1111, 10'b00_0000_0000, 32'h7777_0007, 50, 10);
        set_row(7, "heavy_stall",     10'b01_1001_1001, 10'b00_0000_0000, 32'h8888_0008, 75, 5);

        resetn   = 1'b0;
        pe_valid = '0;
        header   = '0;
        tready   = 1'b1;
        for (int i = 0; i < NUM_PE; i++) begin
            pe_order[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_before = err_cnt;
            row_bad    = 1'b0;
            @(posedge clk);
            #1;
            header = rows[r].hdr;
            pulse_engines(rows[r].valid_mask);
            if (rows[r].second_mask != '0) begin
                @(posedge clk);   // serializer busy here, so no ack.
                #1;
                pulse_engines(rows[r].second_mask);
            end
            total_exp += rows[r].exp_msgs;
            wait_messages(total_exp, rows[r].stall_pct);
            repeat (SETTLE) @(posedge clk);
            #1;
            if (msg_cnt != total_exp) begin
                $display("row %s received %0d messages in total where %0d were expected",
                         rows[r].name, msg_cnt, total_exp);
                row_bad = 1'b1;
            end
            if (err_cnt != err_before) begin
                row_bad = 1'b1;
            end
            if (row_bad) begin
                rows_bad++;
                $display("row %0d %s: failed", r, rows[r].name);
            end else begin
                rows_ok++;
                $display("row %0d %s: ok, %0d messages", r, rows[r].name, rows[r].exp_msgs);
            end
        end

        $display("rows passed %0d, rows failed %0d, check errors %0d",
                 rows_ok, rows_bad, err_cnt);
        if (rows_bad == 0 && err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog over the whole run.
    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles",
                 NUM_ROWS * ROW_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== project.f ====
order_gen_pkg.sv
axis_if.sv
order_buffer.sv
rr_arbiter.sv
payload_serializer.sv
order_payload_top.sv
payload_checker.sv
tb_order_payload.sv

// ==== Bender.yml ====
package:
  name: order_payload

sources:
  - files:
      - order_gen_pkg.sv
      - axis_if.sv
      - order_buffer.sv
      - rr_arbiter.sv
      - payload_serializer.sv
      - order_payload_top.sv
  - target: test
    files:
      - payload_checker.sv
      - tb_order_payload.sv
